// File: src/imu_link_pkg.sv
package imu_link_pkg;

    // --------------------------------------------------
    // Packet geometry
    // --------------------------------------------------

    // Length of one transaction's payload, header and flags included
    localparam int packet_bytes = 16;

    // Width of an index into the byte view of the packet
    localparam int byte_index_w = $clog2(packet_bytes);

    // One more state than there are bytes, so the shifter can mark the packet as sent
    localparam int byte_count_w = $clog2(packet_bytes + 1);

    // First byte on the wire, lets the master find frame alignment
    localparam logic [7:0] header_byte = 8'hAA;

    // --------------------------------------------------
    // Sensor data types
    // --------------------------------------------------

    // One sensor reading in two's complement
    // Field order matches the order on the wire, most significant first
    typedef struct packed {
        logic signed [15:0] quat_w;
        logic signed [15:0] quat_x;
        logic signed [15:0] quat_y;
        logic signed [15:0] quat_z;
        logic signed [15:0] gyro_x;
        logic signed [15:0] gyro_y;
        logic signed [15:0] gyro_z;
    } imu_sample_t;

    // Flags byte sent last in the packet
    // Quaternion valid sits in bit 0 and gyroscope valid in bit 1
    typedef struct packed {
        logic [5:0] reserved;
        logic       gyro_valid;
        logic       quat_valid;
    } imu_flags_t;

    // Named view of the frame, header in the top byte
    typedef struct packed {
        logic [7:0]  header;
        imu_sample_t sample;
        imu_flags_t  flags;
    } imu_packet_fields_t;

    // The same 128 bits seen as fields when assembled and as bytes when shifted
    // Index 0 of the byte view is the most significant byte, so it lines up with the header
    typedef union packed {
        imu_packet_fields_t           fields;
        logic [0:packet_bytes-1][7:0] bytes;
    } imu_packet_t;

endpackage

// File: src/sensor_capture.sv
`timescale 1ns/10ps

module sensor_capture (
    input  logic                      clk,
    input  imu_link_pkg::imu_sample_t sample,
    input  logic                      quat_valid,
    input  logic                      gyro_valid,
    output imu_link_pkg::imu_sample_t sample_reg,
    output imu_link_pkg::imu_flags_t  flags_sync
);
    import imu_link_pkg::*;

    // --------------------------------------------------
    // Sample register
    // --------------------------------------------------

    // Flags after the input register, already in packed form
    imu_flags_t flags_reg;

    // First synchronizer stage, may go metastable
    imu_flags_t flags_meta;

    // The upstream controller builds the sample from combinational logic
    // One register stage removes any glitches before the value is used
    // The sample is visible on sample_reg one clk cycle after it is presented
    always_ff @(posedge clk) begin
        sample_reg <= sample;
    end

    // --------------------------------------------------
    // Valid flag path
    // --------------------------------------------------

    // Each flag is registered next to the sample first
    // Reserved bits are tied to zero here so they are zero on the wire as well
    always_ff @(posedge clk) begin
        flags_reg.reserved   <= '0;
        flags_reg.gyro_valid <= gyro_valid;
        flags_reg.quat_valid <= quat_valid;
    end

    // Two-flop synchronizer on the single-bit flags
    // The flags are level signals with no handshake, so a plain double flop is enough
    // Only one bit changes per flag, which keeps the crossing safe bit by bit
    always_ff @(posedge clk) begin
        flags_meta <= flags_reg;
        flags_sync <= flags_meta;
    end

    // The flags reach flags_sync three clk cycles after they are presented
    // That is two cycles behind the sample they describe
    // The snapshot only freezes after cs_n falls, and the master is expected to hold
    // the sample for four cycles, so both parts line up in the transmitted packet

endmodule

// File: src/packet_snapshot.sv
`timescale 1ns/10ps

module packet_snapshot (
    input  logic                      clk,
    input  logic                      cs_n,
    input  imu_link_pkg::imu_sample_t sample_reg,
    input  imu_link_pkg::imu_flags_t  flags_sync,
    output imu_link_pkg::imu_packet_t packet
);
    import imu_link_pkg::*;

    // --------------------------------------------------
    // Snapshot registers
    // --------------------------------------------------

    // Sample held for the duration of one SPI transaction
    imu_sample_t snap_sample;

    // Flags held alongside the sample
    imu_flags_t  snap_flags;

    // While cs_n is high the snapshot tracks the capture stage on every clk edge
    // While cs_n is low nothing loads, so the frame is frozen for the whole transfer
    // The shifter runs on sck and reads the packet bits without any synchronizer
    // This is safe because the bits cannot move while the master is clocking
    // cs_n itself reaches this block unsynchronized
    // A metastable load enable only matters if the data changes at the same edge,
    // and the sample is required to be stable for several cycles before cs_n falls
    always_ff @(posedge clk) begin
        if (cs_n) begin
            snap_sample <= sample_reg;
            snap_flags  <= flags_sync;
        end
    end

    // --------------------------------------------------
    // Frame assembly
    // --------------------------------------------------

    // The frame is built through the named view of the union
    // The shifter reads the same bits back through the byte view
    // Header comes first, then w, x, y, z, then gyroscope x, y, z, then flags
    always_comb begin
        packet.fields.header = header_byte;
        packet.fields.sample = snap_sample;
        packet.fields.flags  = snap_flags;
    end

    // Byte layout as seen by the master
    //   byte 0        header
    //   bytes 1 to 8  quaternion, high byte first for each word
    //   bytes 9 to 14 gyroscope, high byte first for each word
    //   byte 15       flags
    // Every field is a whole number of bytes, so no word straddles a byte boundary
    // and the byte view can hand out complete bytes without any realignment

    // The header is a constant and is also preloaded by the shifter under reset
    // Carrying it in the frame as well keeps the byte view complete for checking

endmodule

// File: src/spi_miso_shifter.sv
`timescale 1ns/10ps

module spi_miso_shifter (
    input  logic                      cs_n,
    input  logic                      sck,
    input  imu_link_pkg::imu_packet_t packet,
    output logic                      sdo
);
    import imu_link_pkg::*;

    // --------------------------------------------------
    // State
    // --------------------------------------------------

    // Set at the first rising sck edge of a transaction
    logic                    seen_rise;

    // Bit position inside the current byte, 7 means the last bit is on sdo
    logic [2:0]              bit_count;

    // Index of the byte currently in the shift register
    // Reaches packet_bytes once the whole frame has gone out
    logic [byte_count_w-1:0] byte_count;

    // Index of the byte to load at the next byte boundary
    logic [byte_count_w-1:0] next_byte;

    // Byte being shifted out, MSB drives sdo
    logic [7:0]              shift_byte;

    // High while the last bit of the current byte is on sdo
    logic                    last_bit;

    // High while another frame byte remains to be loaded
    logic                    more_bytes;

    // --------------------------------------------------
    // First edge qualifier
    // --------------------------------------------------

    // In mode 0 the master samples on the rising edge and the slave moves on the falling edge
    // A master may start with a stray falling edge right after lowering cs_n
    // Shifting is therefore held off until a rising edge has sampled the header MSB
    always_ff @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            seen_rise <= 1'b0;
        end else begin
            seen_rise <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Shift register and counters
    // --------------------------------------------------

    assign last_bit   = (bit_count == 3'd7);
    assign next_byte  = byte_count + 1'b1;
    assign more_bytes = (next_byte < byte_count_w'(packet_bytes));

    // High cs_n resets the shifter asynchronously and preloads the header
    // so sdo already carries header bit 7 when cs_n goes low
    // An aborted transfer ends with cs_n high, so the next one restarts at the header
    always_ff @(negedge sck or posedge cs_n) begin
        if (cs_n) begin
            bit_count  <= '0;
            byte_count <= '0;
            shift_byte <= header_byte;
        end else if (seen_rise) begin
            // The counter wraps from 7 back to 0 at each byte boundary
            bit_count <= bit_count + 1'b1;
            if (!last_bit) begin
                // Next bit moves up into the MSB, MSB first on the wire
                shift_byte <= {shift_byte[6:0], 1'b0};
            end else if (more_bytes) begin
                // Byte boundary, fetch the next byte of the frozen frame
                byte_count <= next_byte;
                shift_byte <= packet.bytes[next_byte[byte_index_w-1:0]];
            end else begin
                // Frame done, park the counter and feed zeros from here on
                byte_count <= byte_count_w'(packet_bytes);
                shift_byte <= '0;
            end
        end
    end

    // --------------------------------------------------
    // MISO driver
    // --------------------------------------------------

    // sdo is only driven while this slave is selected
    // Other devices on the bus may own the line while cs_n is high
    assign sdo = cs_n ? 1'bz : shift_byte[7];

    // Bit k of the frame is on sdo at the k-th rising sck edge after cs_n falls
    // Bit 0 comes from the preload, later bits from falling edges after the first rise
    // Once 128 bits are out the register holds zero, so sdo stays low until cs_n rises

endmodule

// File: src/imu_spi_link.sv
`timescale 1ns/10ps

module imu_spi_link (
    input  logic                      clk,
    input  logic                      cs_n,
    input  logic                      sck,
    input  logic                      sdi,
    output logic                      sdo,
    input  logic                      quat_valid,
    input  logic                      gyro_valid,
    input  imu_link_pkg::imu_sample_t sample
);
    import imu_link_pkg::*;

    // The link is read-only, so data from the master on sdi is never looked at
    // The master clocks out dummy bytes only to generate sck

    // --------------------------------------------------
    // Internal wires
    // --------------------------------------------------

    // Registered sample in the clk domain
    imu_sample_t sample_reg;

    // Valid flags after the synchronizer
    imu_flags_t  flags_sync;

    // Frame frozen for the current transaction
    imu_packet_t packet;

    // --------------------------------------------------
    // clk domain
    // --------------------------------------------------

    // Removes glitches from the sample and synchronizes the valid flags
    sensor_capture u_capture (
        .clk        (clk),
        .sample     (sample),
        .quat_valid (quat_valid),
        .gyro_valid (gyro_valid),
        .sample_reg (sample_reg),
        .flags_sync (flags_sync)
    );

    // Follows the capture stage while idle and freezes while cs_n is low
    packet_snapshot u_snapshot (
        .clk        (clk),
        .cs_n       (cs_n),
        .sample_reg (sample_reg),
        .flags_sync (flags_sync),
        .packet     (packet)
    );

    // --------------------------------------------------
    // sck domain
    // --------------------------------------------------

    // Walks the frame out on sdo in SPI mode 0
    spi_miso_shifter u_shifter (
        .cs_n   (cs_n),
        .sck    (sck),
        .packet (packet),
        .sdo    (sdo)
    );

endmodule

// File: tests/imu_spi_link_properties.sv
`timescale 1ns/10ps

module imu_spi_link_properties (
    input logic                      clk,
    input logic                      cs_n,
    input logic                      sck,
    input logic                      sdo,
    input imu_link_pkg::imu_packet_t packet
);

    // Count of failed assertions over the whole run
    int failures = 0;

    // --------------------------------------------------
    // Shifter output timing
    // --------------------------------------------------

    // In mode 0 the slave only moves sdo on a falling sck edge
    // Two clk samples in a row with sck low must see the same sdo level
    property sdo_held_while_sck_low;
        @(posedge clk) disable iff (cs_n)
            (!$past(cs_n) && !sck && !$past(sck)) |-> $stable(sdo);
    endproperty

    // The master samples during the high phase, so sdo must not move there either
    property sdo_held_while_sck_high;
        @(posedge clk) disable iff (cs_n)
            (!$past(cs_n) && sck && $past(sck)) |-> $stable(sdo);
    endproperty

    // --------------------------------------------------
    // Snapshot freeze
    // --------------------------------------------------

    // Once cs_n was low at the previous clk edge no further load may happen
    // The frame read by the sck domain is therefore constant for the transfer
    property packet_frozen_while_selected;
        @(posedge clk) disable iff (cs_n)
            !$past(cs_n) |-> $stable(packet);
    endproperty

    sdo_low_phase_check: assert property (sdo_held_while_sck_low)
        else begin
            failures++;
            $error("sdo changed while sck was low");
        end

    sdo_high_phase_check: assert property (sdo_held_while_sck_high)
        else begin
            failures++;
            $error("sdo changed while sck was high");
        end

    packet_freeze_check: assert property (packet_frozen_while_selected)
        else begin
            failures++;
            $error("Snapshot packet changed while cs_n was low");
        end

endmodule

// The top level holds both the clk side of the snapshot and the sck side of the shifter
bind imu_spi_link imu_spi_link_properties u_properties (
    .clk    (clk),
    .cs_n   (cs_n),
    .sck    (sck),
    .sdo    (sdo),
    .packet (packet)
);

// File: tests/imu_spi_link_tb.sv
`timescale 1ns/10ps

module imu_spi_link_tb;
    import imu_link_pkg::*;

    // --------------------------------------------------
    // Run geometry
    // --------------------------------------------------

    localparam int num_rows       = 8;
    localparam int directed_rows  = 4;
    localparam int abort_row      = 5;
    localparam int abort_bits     = 20;
    // One byte past the frame so the trailing zeros are read as well
    localparam int read_bytes     = packet_bytes + 1;
    localparam int read_bits      = read_bytes * 8;
    localparam int cycles_per_row = 6 + read_bits * 4 + 8;
    localparam int timeout_cycles = 2 * num_rows * cycles_per_row;

    // One stimulus row with the packet it must produce on the wire
    typedef struct packed {
        imu_sample_t sample;
        logic        quat_valid;
        logic        gyro_valid;
        imu_packet_t expected;
    } table_row_t;

    logic        clk;
    logic        cs_n;
    logic        sck;
    logic        sdi;
    logic        sdo;
    logic        quat_valid;
    logic        gyro_valid;
    imu_sample_t sample;

    table_row_t  table_rows [0:num_rows-1];
    logic [7:0]  rx_bytes [0:read_bytes-1];
    logic [31:0] lcg_state       = 32'hcf4f45ca;
    int          cycle_count     = 0;
    int          check_count     = 0;
    int          error_count     = 0;
    int          assert_failures = 0;

    imu_spi_link DUT (
        .clk        (clk),
        .cs_n       (cs_n),
        .sck        (sck),
        .sdi        (sdi),
        .sdo        (sdo),
        .quat_valid (quat_valid),
        .gyro_valid (gyro_valid),
        .sample     (sample)
    );

    // 4 ns clock period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // Stimulus and expected values
    // --------------------------------------------------

    // Linear congruential step that returns the better distributed upper half of the state
    function automatic logic [15:0] random_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic imu_sample_t random_sample();
        imu_sample_t s;
        s.quat_w = random_word();
        s.quat_x = random_word();
        s.quat_y = random_word();
        s.quat_z = random_word();
        s.gyro_x = random_word();
        s.gyro_y = random_word();
        s.gyro_z = random_word();
        return s;
    endfunction

    function automatic imu_sample_t uniform_sample(logic [15:0] value);
        imu_sample_t s;
        s.quat_w = value;
        s.quat_x = value;
        s.quat_y = value;
        s.quat_z = value;
        s.gyro_x = value;
        s.gyro_y = value;
        s.gyro_z = value;
        return s;
    endfunction

    // The packet on the wire is 0xAA, then seven words high byte first, then the flags byte
    function automatic imu_packet_t build_expected(imu_sample_t s, logic qv, logic gv);
        imu_packet_t pkt;
        logic [15:0] words [0:6];
        words[0] = s.quat_w;
        words[1] = s.quat_x;
        words[2] = s.quat_y;
        words[3] = s.quat_z;
        words[4] = s.gyro_x;
        words[5] = s.gyro_y;
        words[6] = s.gyro_z;
        pkt.bytes[0] = 8'hAA;
        for (int i = 0; i < 7; i++) begin
            pkt.bytes[1 + 2 * i] = words[i][15:8];
            pkt.bytes[2 + 2 * i] = words[i][7:0];
        end
        pkt.bytes[15] = {6'b000000, gv, qv};
        return pkt;
    endfunction

    function automatic table_row_t make_row(imu_sample_t s, logic qv, logic gv);
        table_row_t row;
        row.sample     = s;
        row.quat_valid = qv;
        row.gyro_valid = gv;
        row.expected   = build_expected(s, qv, gv);
        return row;
    endfunction

    // Directed rows hit the extremes and all four flag combinations
    task automatic fill_table();
        imu_sample_t mixed;
        logic [15:0] flag_word;
        mixed.quat_w = 16'h1234;
        mixed.quat_x = 16'h7FFF;
        mixed.quat_y = 16'h8000;
        mixed.quat_z = 16'h0000;
        mixed.gyro_x = 16'h1234;
        mixed.gyro_y = 16'h8000;
        mixed.gyro_z = 16'h7FFF;
        table_rows[0] = make_row(uniform_sample(16'h7FFF), 1'b0, 1'b0);
        table_rows[1] = make_row(uniform_sample(16'h8000), 1'b1, 1'b0);
        table_rows[2] = make_row(uniform_sample(16'h0000), 1'b0, 1'b1);
        table_rows[3] = make_row(mixed, 1'b1, 1'b1);
        for (int i = directed_rows; i < num_rows; i++) begin
            flag_word     = random_word();
            table_rows[i] = make_row(random_sample(), flag_word[5], flag_word[9]);
        end
    endtask

    // --------------------------------------------------
    // Drivers and checks
    // --------------------------------------------------

    task automatic apply_row(table_row_t row);
        @(negedge clk);
        sample     = row.sample;
        quat_valid = row.quat_valid;
        gyro_valid = row.gyro_valid;
    endtask

    // SPI mode 0 master with an sck half period of two clk cycles
    // With scramble set the sensor inputs change right after cs_n falls
    task automatic spi_transfer(int num_bits, logic scramble);
        int bit_index;
        for (int i = 0; i < read_bytes; i++) begin
            rx_bytes[i] = 8'h00;
        end
        @(negedge clk);
        cs_n = 1'b0;
        if (scramble) begin
            @(negedge clk);
            sample     = random_sample();
            quat_valid = ~quat_valid;
            gyro_valid = ~gyro_valid;
        end
        for (bit_index = 0; bit_index < num_bits; bit_index++) begin
            repeat (2) @(negedge clk);
            sck = 1'b1;
            // Sampled inside the high phase where sdo is steady
            @(posedge clk);
            rx_bytes[bit_index / 8] = {rx_bytes[bit_index / 8][6:0], sdo};
            repeat (2) @(negedge clk);
            sck = 1'b0;
        end
        repeat (2) @(negedge clk);
        cs_n = 1'b1;
    endtask

    task automatic compare_value(string name, logic [7:0] expected, logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic check_transfer(int row);
        for (int b = 0; b < packet_bytes; b++) begin
            compare_value($sformatf("rx_byte[%0d] row %0d", b, row),
                          table_rows[row].expected.bytes[b], rx_bytes[b]);
        end
        compare_value($sformatf("rx_byte[%0d] row %0d", packet_bytes, row),
                      8'h00, rx_bytes[packet_bytes]);
    endtask

    // --------------------------------------------------
    // Timeout and main sequence
    // --------------------------------------------------

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: transfer did not finish");
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        cs_n       = 1'b1;
        sck        = 1'b0;
        sdi        = 1'b0;
        quat_valid = 1'b0;
        gyro_valid = 1'b0;
        sample     = '0;
        fill_table();
        // A high cs_n is the reset of the shifter
        repeat (2) @(negedge clk);

        for (int row = 0; row < num_rows; row++) begin
            // An aborted read of the previous data comes first so the next read
            // must restart at the header
            if (row == abort_row) begin
                spi_transfer(abort_bits, 1'b0);
            end
            apply_row(table_rows[row]);
            repeat (6) @(negedge clk);
            spi_transfer(read_bits, 1'b1);
            check_transfer(row);
        end

        assert_failures = DUT.u_properties.failures;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
src/imu_link_pkg.sv
src/sensor_capture.sv
src/packet_snapshot.sv
src/spi_miso_shifter.sv
src/imu_spi_link.sv
tests/imu_spi_link_properties.sv
tests/imu_spi_link_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the SPI link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module imu_spi_link_tb -o imu_spi_link_sim \
    || { echo "Build failed"; exit 1; }

./obj_dir/imu_spi_link_sim | tee /dev/stderr | grep -F -- '*** PASSED ***' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
